// ==== dv/adc_input.txt ====
// columns in hex: opcode argument comparator_delay mode expected_reset expected_runup
// opcode 00 sends only the start, delay ffffffff (-1) draws a random delay
// mode 0 plain conversion, 1 extra start and readback while busy, 2 abort in run-up
00 00 00000010 0 14 190
3a 05 ffffffff 0 14 14
3a 01 00000003 0 14 04
3a 00 00000020 1 14 190
77 00 00000008 0 14 190
3a 32 00000000 2 14 c8
00 00 ffffffff 0 14 c8
3a 03 00000005 0 14 0c
3a 64 ffffffff 1 14 190
00 00 00000001 0 14 190

// ==== files.f ====
source/adc_spi_pkg.sv
source/adc_seq_pkg.sv
source/spi_byte_rx.sv
source/adc_cmd_decode.sv
source/integrator_sequencer.sv
source/count_readback.sv
source/adc_spi_top.sv
dv/adc_spi_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator
# exits non-zero when the build fails, the run fails or the log reports a failure

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=adc_spi_sim

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module adc_spi_tb \
  -f files.f \
  -Mdir "$OBJ" -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
  echo "simulation reported a failure, see $LOG"
  exit 1
fi

exit 0

// ==== dv/adc_spi_tb.sv ====
module adc_spi_tb;

  timeunit 1ns;
  timeprecision 1ps;

  // shortened timing for simulation
  localparam int RESET_CYCLES = 20;
  localparam int RUNUP_UNIT   = 4;
  // sck half period in clk cycles
  localparam int HALF = 4;
  // driven eighth sck rise to monitored m_short rise, minus the reset phase
  // two sync stages, byte flag, request, start taken, one monitor sample
  localparam int START_LAT = 6;
  // columns per test line in the data file
  localparam int FIELDS     = 6;
  localparam int MAX_TESTS  = 16;
  // spi frames per test, worst case
  localparam int SPI_MARGIN = 1500;

  logic clk;
  logic arst_n;
  logic sck;
  logic ssel;
  logic mosi;
  logic miso;
  logic t_trigger;
  logic m_short;
  logic m_in;
  logic m_ref;

  logic [31:0] stim_mem [0:MAX_TESTS*FIELDS-1];

  // owned by the main process
  int errors        = 0;
  int n_run         = 0;
  int n_failed      = 0;
  int last_rise_cyc = 0;
  int trig_delay    = 0;
  int seed          = 22;
  int cycle_limit   = 0;

  // owned by the monitor
  int   cyc            = 0;
  int   short_rise_cyc = 0;
  int   runup_cnt      = 0;
  int   rundown_cnt    = 0;
  int   conv_done      = 0;
  int   ref_errors     = 0;
  logic short_q        = 1'b0;
  logic in_q           = 1'b0;

  adc_spi_top #(
    .RESET_CYCLES (RESET_CYCLES),
    .RUNUP_UNIT   (RUNUP_UNIT)
  ) adc_spi_top_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .sck       (sck),
    .ssel      (ssel),
    .mosi      (mosi),
    .miso      (miso),
    .t_trigger (t_trigger),
    .m_short   (m_short),
    .m_in      (m_in),
    .m_ref     (m_ref)
  );

  // 8 ns clock
  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic expect_equal(input string name, input logic [31:0] actual,
                              input logic [31:0] expected, inout int fails);
    if (actual !== expected)
    begin
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
      fails++;
    end
  endtask

  // one spi frame, mode 0, msb first, miso taken on each rising sck
  task automatic spi_frame(input logic [31:0] tx_word, input int nbytes,
                           output logic [31:0] rx_word);
    logic [31:0] tx;
    int          i;
    tx      = tx_word;
    rx_word = '0;
    @(posedge clk);
    ssel <= 1'b0;
    for (i = 0; i < nbytes * 8; i++)
    begin
      mosi <= tx[31];
      tx = tx << 1;
      repeat (HALF) @(posedge clk);
      sck <= 1'b1;
      rx_word = {rx_word[30:0], miso};
      last_rise_cyc = cyc;
      repeat (HALF) @(posedge clk);
      sck <= 1'b0;
    end
    repeat (HALF) @(posedge clk);
    ssel <= 1'b1;
    repeat (2 * HALF) @(posedge clk);
  endtask

  // 32 bit readback, filler bytes are unknown opcodes
  task automatic read_result(output logic [31:0] value);
    spi_frame(32'h0000_0000, 4, value);
  endtask

  task automatic report_test(input string label, input int errs_before);
    n_run++;
    if (errors + ref_errors == errs_before)
      $display("%s: ok", label);
    else
    begin
      n_failed++;
      $display("%s: failed with %0d errors", label, errors + ref_errors - errs_before);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // port monitor, counts phase lengths
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
    if (!arst_n)
    begin
      short_q <= 1'b0;
      in_q    <= 1'b0;
    end
    else
    begin
      short_q <= m_short;
      in_q    <= m_in;
      // reference switch mirrors the input switch
      expect_equal("m_ref", 32'(m_ref), 32'(!m_in), ref_errors);
      // run-up starts on the m_short rise
      if (m_short && !short_q)
      begin
        short_rise_cyc <= cyc;
        runup_cnt      <= 1;
      end
      else if (m_short && !m_in)
        runup_cnt <= runup_cnt + 1;
      if (m_in && !in_q)
        rundown_cnt <= 1;
      else if (m_in)
        rundown_cnt <= rundown_cnt + 1;
      // m_in falling marks the end of conversion
      if (!m_in && in_q)
        conv_done <= conv_done + 1;
    end
  end

  // comparator flips a set number of cycles after m_in rises
  initial
  begin
    logic in_seen;
    in_seen   = 1'b0;
    t_trigger = 1'b0;
    forever
    begin
      @(posedge clk);
      if (m_in && !in_seen)
      begin
        repeat (trig_delay) @(posedge clk);
        t_trigger <= ~t_trigger;
      end
      in_seen = m_in;
    end
  end

  // watchdog
  initial
  begin
    wait (cycle_limit > 0);
    wait (cyc >= cycle_limit);
    $display("timeout: tests did not finish within %0d cycles", cycle_limit);
    $display("Result: FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    logic [31:0] rx;
    logic [31:0] delay_raw;
    logic [7:0]  op;
    logic [7:0]  arg;
    int          mode;
    int          exp_reset;
    int          exp_runup;
    int          n_tests;
    int          errs_before;
    int          done_before;
    int          start_mark;
    int          t;

    arst_n = 1'b0;
    sck    = 1'b0;
    ssel   = 1'b1;
    mosi   = 1'b0;

    // unused rows hold an out of range opcode that marks the end
    for (t = 0; t < MAX_TESTS * FIELDS; t++)
      stim_mem[t] = 32'h8000_0000 | 32'(t);
    $readmemh("dv/adc_input.txt", stim_mem);
    n_tests = 0;
    while (n_tests < MAX_TESTS && stim_mem[n_tests*FIELDS] <= 32'h0000_00FF)
      n_tests++;
    if (n_tests == 0)
    begin
      $display("no tests found in dv/adc_input.txt");
      errors++;
    end

    // phase lengths plus comparator delay plus spi traffic per test
    cycle_limit = 2000;
    for (t = 0; t < n_tests; t++)
    begin
      delay_raw   = stim_mem[t*FIELDS+2];
      cycle_limit = cycle_limit + int'(stim_mem[t*FIELDS+4]) + int'(stim_mem[t*FIELDS+5]);
      cycle_limit = cycle_limit + SPI_MARGIN + ((delay_raw == 32'hFFFF_FFFF) ? 64 : delay_raw);
    end

    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    repeat (2) @(posedge clk);

    // power-up state
    errs_before = errors + ref_errors;
    expect_equal("m_short", 32'(m_short), 32'd0, errors);
    expect_equal("m_in", 32'(m_in), 32'd0, errors);
    expect_equal("m_ref", 32'(m_ref), 32'd1, errors);
    read_result(rx);
    expect_equal("readback after reset", rx, 32'd0, errors);
    report_test("power-up", errs_before);

    for (t = 0; t < n_tests; t++)
    begin
      errs_before = errors + ref_errors;
      op          = stim_mem[t*FIELDS][7:0];
      arg         = stim_mem[t*FIELDS+1][7:0];
      delay_raw   = stim_mem[t*FIELDS+2];
      mode        = stim_mem[t*FIELDS+3];
      exp_reset   = stim_mem[t*FIELDS+4];
      exp_runup   = stim_mem[t*FIELDS+5];
      if (delay_raw == 32'hFFFF_FFFF)
        trig_delay = $random(seed) & 63;
      else
        trig_delay = delay_raw;

      // optional command ahead of the start
      if (op == adc_spi_pkg::OP_SET_RUNUP)
        spi_frame({op, arg, 16'h0000}, 2, rx);
      else if (op != 8'h00)
        spi_frame({op, 24'h000000}, 1, rx);

      done_before = conv_done;
      spi_frame({adc_spi_pkg::OP_START, 24'h000000}, 1, rx);
      start_mark = last_rise_cyc;

      // second start while busy, result reads as zero meanwhile
      if (mode == 1)
      begin
        spi_frame({adc_spi_pkg::OP_START, 24'h000000}, 4, rx);
        expect_equal("readback during conversion", rx, 32'd0, errors);
      end

      if (mode == 2)
      begin
        while (!m_short)
          @(posedge clk);
        spi_frame({adc_spi_pkg::OP_ABORT, 24'h000000}, 1, rx);
        expect_equal("m_short after abort", 32'(m_short), 32'd0, errors);
        expect_equal("m_in after abort", 32'(m_in), 32'd0, errors);
        expect_equal("m_ref after abort", 32'(m_ref), 32'd1, errors);
        read_result(rx);
        expect_equal("readback after abort", rx, 32'd0, errors);
        expect_equal("conversions finished", 32'(conv_done), 32'(done_before), errors);
        expect_equal("m_short idle after abort", 32'(m_short), 32'd0, errors);
      end
      else
      begin
        while (conv_done == done_before)
          @(posedge clk);
        expect_equal("reset phase cycles", 32'(short_rise_cyc - start_mark - START_LAT),
                     32'(exp_reset), errors);
        expect_equal("run-up cycles", 32'(runup_cnt), 32'(exp_runup), errors);
        read_result(rx);
        expect_equal("readback", rx, 32'(rundown_cnt), errors);
      end
      report_test($sformatf("test %0d op %02h arg %02h mode %0d", t, op, arg, mode),
                  errs_before);
    end

    $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
             n_run, n_run - n_failed, n_failed, errors + ref_errors);
    if (errors + ref_errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== source/adc_spi_top.sv ====
module adc_spi_top #(
  parameter int RESET_CYCLES       = 10000,
  parameter int RUNUP_UNIT         = 1000,
  parameter int RUNUP_DEFAULT_MULT = 100,
  parameter int SYNC_STAGES        = 3
) (
  input  logic clk,
  input  logic arst_n,
  // spi pins, ssel active low
  input  logic sck,
  input  logic ssel,
  input  logic mosi,
  output logic miso,
  // comparator, asynchronous to clk
  input  logic t_trigger,
  // analog switch lines
  output logic m_short,
  output logic m_in,
  output logic m_ref
);

  // receiver to decoder and readback
  logic                             byte_valid;
  logic [adc_spi_pkg::BYTE_W-1:0]   byte_data;
  logic                             frame_active;
  logic                             frame_start;
  logic                             sck_fall;

  // command handshake
  logic                             cmd_req;
  logic                             cmd_ack;
  logic                             cmd_start;
  logic                             cmd_abort;
  logic [adc_spi_pkg::BYTE_W-1:0]   runup_mult;

  // result path
  logic                             result_valid;
  logic [adc_seq_pkg::COUNT_W-1:0]  result_count;
  logic                             clear_result;

  //////////////////////////////////////////////////////////////////////
  // spi receive and command decode
  //////////////////////////////////////////////////////////////////////

  spi_byte_rx #(
    .SYNC_STAGES (SYNC_STAGES)
  ) spi_byte_rx_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .sck          (sck),
    .ssel         (ssel),
    .mosi         (mosi),
    .byte_valid   (byte_valid),
    .byte_data    (byte_data),
    .frame_active (frame_active),
    .frame_start  (frame_start),
    .sck_fall     (sck_fall)
  );

  adc_cmd_decode adc_cmd_decode_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .byte_valid   (byte_valid),
    .byte_data    (byte_data),
    .frame_active (frame_active),
    .cmd_ack      (cmd_ack),
    .cmd_req      (cmd_req),
    .cmd_start    (cmd_start),
    .cmd_abort    (cmd_abort),
    .runup_mult   (runup_mult)
  );

  //////////////////////////////////////////////////////////////////////
  // conversion and readback
  //////////////////////////////////////////////////////////////////////

  integrator_sequencer #(
    .RESET_CYCLES       (RESET_CYCLES),
    .RUNUP_UNIT         (RUNUP_UNIT),
    .RUNUP_DEFAULT_MULT (RUNUP_DEFAULT_MULT),
    .SYNC_STAGES        (SYNC_STAGES)
  ) integrator_sequencer_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .cmd_req      (cmd_req),
    .cmd_start    (cmd_start),
    .cmd_abort    (cmd_abort),
    .runup_mult   (runup_mult),
    .t_trigger    (t_trigger),
    .cmd_ack      (cmd_ack),
    .m_short      (m_short),
    .m_in         (m_in),
    .m_ref        (m_ref),
    .result_valid (result_valid),
    .result_count (result_count),
    .clear_result (clear_result)
  );

  count_readback count_readback_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .result_valid (result_valid),
    .result_count (result_count),
    .clear_result (clear_result),
    .frame_start  (frame_start),
    .sck_fall     (sck_fall),
    .miso         (miso)
  );

endmodule

// ==== source/count_readback.sv ====
module count_readback (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            result_valid,
  input  logic [adc_seq_pkg::COUNT_W-1:0] result_count,
  input  logic                            clear_result,
  input  logic                            frame_start,
  input  logic                            sck_fall,
  output logic                            miso
);

  localparam int CW = adc_seq_pkg::COUNT_W;

  // last finished conversion, zero while one is running
  logic [CW-1:0] held_result;
  // outgoing word, msb on the pin
  logic [CW-1:0] tx_shift;

  //////////////////////////////////////////////////////////////////////
  // held result
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      held_result <= '0;
    else if (clear_result)
      // a start was taken, host reads zero until done
      held_result <= '0;
    else if (result_valid)
      held_result <= result_count;
  end

  //////////////////////////////////////////////////////////////////////
  // readback shift register
  //////////////////////////////////////////////////////////////////////

  // loaded at frame start so bit 31 is out before the first sck edge
  // host samples on rising sck, next bit goes out on falling sck
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      tx_shift <= '0;
    else if (frame_start)
      tx_shift <= held_result;
    else if (sck_fall)
      tx_shift <= {tx_shift[CW-2:0], 1'b0};
  end

  // single slave on the bus, miso driven all the time
  assign miso = tx_shift[CW-1];

endmodule

// ==== source/integrator_sequencer.sv ====
module integrator_sequencer #(
  parameter int RESET_CYCLES       = 10000,
  parameter int RUNUP_UNIT         = 1000,
  parameter int RUNUP_DEFAULT_MULT = 100,
  parameter int SYNC_STAGES        = 3
) (
  input  logic                             clk,
  input  logic                             arst_n,
  input  logic                             cmd_req,
  input  logic                             cmd_start,
  input  logic                             cmd_abort,
  input  logic [adc_spi_pkg::BYTE_W-1:0]   runup_mult,
  input  logic                             t_trigger,
  output logic                             cmd_ack,
  output logic                             m_short,
  output logic                             m_in,
  output logic                             m_ref,
  output logic                             result_valid,
  output logic [adc_seq_pkg::COUNT_W-1:0]  result_count,
  output logic                             clear_result
);

  localparam int CW = adc_seq_pkg::COUNT_W;

  adc_seq_pkg::seq_phase_t phase;

  // one timer reused by reset, run-up and run-down
  logic [CW-1:0] timer;
  // run-up length latched when a start is taken
  logic [CW-1:0] runup_len;
  logic [CW-1:0] next_runup_len;
  // last programmed multiplier, zero selects the default
  logic [adc_spi_pkg::BYTE_W-1:0] stored_mult;
  logic [SYNC_STAGES-1:0] trig_q;
  logic trig_edge;
  // first cycle of a request, ack not yet raised
  logic cmd_take;

  //////////////////////////////////////////////////////////////////////
  // comparator synchronizer, either edge ends run-down
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      trig_q <= '0;
    else
      trig_q <= {trig_q[SYNC_STAGES-2:0], t_trigger};
  end

  assign trig_edge = trig_q[SYNC_STAGES-1] ^ trig_q[SYNC_STAGES-2];
  assign cmd_take  = cmd_req && !cmd_ack;

  assign next_runup_len = (stored_mult == '0)
    ? CW'(RUNUP_DEFAULT_MULT) * CW'(RUNUP_UNIT)
    : CW'(stored_mult) * CW'(RUNUP_UNIT);

  //////////////////////////////////////////////////////////////////////
  // phase sequencing and switch control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      phase        <= adc_seq_pkg::PH_IDLE;
      timer        <= '0;
      runup_len    <= '0;
      stored_mult  <= '0;
      cmd_ack      <= 1'b0;
      m_short      <= 1'b0;
      m_in         <= 1'b0;
      m_ref        <= 1'b1;
      result_valid <= 1'b0;
      clear_result <= 1'b0;
    end
    else
    begin
      // ack simply follows req, giving the four-phase order
      cmd_ack      <= cmd_req;
      result_valid <= 1'b0;
      clear_result <= 1'b0;
      if (cmd_take && cmd_abort)
      begin
        // abort from any phase, held result untouched
        phase   <= adc_seq_pkg::PH_IDLE;
        m_short <= 1'b0;
        m_in    <= 1'b0;
        m_ref   <= 1'b1;
      end
      else
      begin
        // set run-up in any phase, used from the next start on
        if (cmd_take && !cmd_start)
          stored_mult <= runup_mult;
        case (phase)
          adc_seq_pkg::PH_IDLE:
          begin
            // a start elsewhere is acked but ignored
            if (cmd_take && cmd_start)
            begin
              phase        <= adc_seq_pkg::PH_RESET;
              timer        <= '0;
              runup_len    <= next_runup_len;
              clear_result <= 1'b1;
            end
          end
          adc_seq_pkg::PH_RESET:
          begin
            if (timer == CW'(RESET_CYCLES - 1))
            begin
              phase   <= adc_seq_pkg::PH_RUNUP;
              timer   <= '0;
              m_short <= 1'b1;
            end
            else
              timer <= timer + CW'(1);
          end
          adc_seq_pkg::PH_RUNUP:
          begin
            if (timer == runup_len - CW'(1))
            begin
              // swap input for reference, count from zero
              phase <= adc_seq_pkg::PH_RUNDOWN;
              timer <= '0;
              m_in  <= 1'b1;
              m_ref <= 1'b0;
            end
            else
              timer <= timer + CW'(1);
          end
          adc_seq_pkg::PH_RUNDOWN:
          begin
            if (trig_edge)
            begin
              phase        <= adc_seq_pkg::PH_IDLE;
              m_short      <= 1'b0;
              m_in         <= 1'b0;
              m_ref        <= 1'b1;
              result_valid <= 1'b1;
            end
            else
              timer <= timer + CW'(1);
          end
          default:
            phase <= adc_seq_pkg::PH_IDLE;
        endcase
      end
    end
  end

  // cycles with m_in high, the current one included
  always_ff @(posedge clk)
  begin
    if (phase == adc_seq_pkg::PH_RUNDOWN && trig_edge)
      result_count <= timer + CW'(1);
  end

  // integrator is never fed while shorted
  a_in_needs_short : assert property (
    @(posedge clk) disable iff (!arst_n)
    m_in |-> m_short
  );

  // input and reference switches are never closed together
  a_in_ref_excl : assert property (
    @(posedge clk) disable iff (!arst_n)
    !(m_in && m_ref)
  );

endmodule

// ==== source/adc_cmd_decode.sv ====
module adc_cmd_decode (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           byte_valid,
  input  logic [adc_spi_pkg::BYTE_W-1:0] byte_data,
  input  logic                           frame_active,
  input  logic                           cmd_ack,
  output logic                           cmd_req,
  output logic                           cmd_start,
  output logic                           cmd_abort,
  output logic [adc_spi_pkg::BYTE_W-1:0] runup_mult
);

  // set after OP_SET_RUNUP, next byte is the argument
  logic expect_arg;

  logic op_byte;
  logic issue_start;
  logic issue_abort;
  logic issue_set;
  logic new_cmd;
  // handshake open from req rise until ack falls
  logic hs_open;

  //////////////////////////////////////////////////////////////////////
  // byte classification
  //////////////////////////////////////////////////////////////////////

  assign op_byte     = byte_valid && frame_active && !expect_arg;
  assign issue_start = op_byte && (byte_data == adc_spi_pkg::OP_START);
  assign issue_abort = op_byte && (byte_data == adc_spi_pkg::OP_ABORT);
  assign issue_set   = byte_valid && frame_active && expect_arg;
  assign new_cmd     = issue_start || issue_abort || issue_set;
  assign hs_open     = cmd_req || cmd_ack;

  // framing keeps tracking bytes even while a handshake is open,
  // so a dropped set command does not misread its argument as an opcode
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      expect_arg <= 1'b0;
    else if (!frame_active)
      // frame ended, a half received command is dropped
      expect_arg <= 1'b0;
    else if (byte_valid)
      expect_arg <= !expect_arg && (byte_data == adc_spi_pkg::OP_SET_RUNUP);
  end

  //////////////////////////////////////////////////////////////////////
  // four-phase request side
  //////////////////////////////////////////////////////////////////////

  // req rises on a new command, falls once ack is seen
  // commands arriving while the handshake is open are lost
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      cmd_req   <= 1'b0;
      cmd_start <= 1'b0;
      cmd_abort <= 1'b0;
    end
    else if (cmd_req && cmd_ack)
      cmd_req <= 1'b0;
    else if (new_cmd && !hs_open)
    begin
      cmd_req   <= 1'b1;
      cmd_start <= issue_start;
      cmd_abort <= issue_abort;
    end
  end

  // argument byte, only loaded with a set command
  always_ff @(posedge clk)
  begin
    if (issue_set && !hs_open)
      runup_mult <= byte_data;
  end

  // fields stay put for the whole request
  a_fields_stable : assert property (
    @(posedge clk) disable iff (!arst_n)
    cmd_req && $past(cmd_req) |-> $stable({cmd_start, cmd_abort, runup_mult})
  );

endmodule

// ==== source/spi_byte_rx.sv ====
module spi_byte_rx #(
  parameter int SYNC_STAGES = 3
) (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           sck,
  input  logic                           ssel,
  input  logic                           mosi,
  output logic                           byte_valid,
  output logic [adc_spi_pkg::BYTE_W-1:0] byte_data,
  output logic                           frame_active,
  output logic                           frame_start,
  output logic                           sck_fall
);

  localparam int BW = adc_spi_pkg::BYTE_W;
  localparam int CW = adc_spi_pkg::BIT_CNT_W;

  //////////////////////////////////////////////////////////////////////
  // pin synchronizers
  //////////////////////////////////////////////////////////////////////

  // index 0 is the newest sample, edges use the two oldest stages
  logic [SYNC_STAGES-1:0] sck_q;
  logic [SYNC_STAGES-1:0] ssel_q;
  // mosi is one stage shorter so its last stage lines up with
  // the newer of the two sck stages used for edge detection
  logic [SYNC_STAGES-2:0] mosi_q;

  logic       sck_rise;
  logic [CW-1:0] bit_cnt;
  logic [BW-1:0] rx_shift;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      // spi mode 0, sck idles low and ssel idles high
      sck_q  <= '0;
      ssel_q <= '1;
      mosi_q <= '0;
    end
    else
    begin
      sck_q  <= {sck_q[SYNC_STAGES-2:0], sck};
      ssel_q <= {ssel_q[SYNC_STAGES-2:0], ssel};
      mosi_q <= (mosi_q << 1) | (SYNC_STAGES-1)'(mosi);
    end
  end

  // edge pulses, older stage vs newer stage
  assign sck_rise     = !sck_q[SYNC_STAGES-1] && sck_q[SYNC_STAGES-2];
  assign sck_fall     = sck_q[SYNC_STAGES-1] && !sck_q[SYNC_STAGES-2];
  assign frame_start  = ssel_q[SYNC_STAGES-1] && !ssel_q[SYNC_STAGES-2];
  // ssel is active low
  assign frame_active = !ssel_q[SYNC_STAGES-2];

  //////////////////////////////////////////////////////////////////////
  // byte assembly
  //////////////////////////////////////////////////////////////////////

  // bit counter restarts whenever the slave is deselected
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      bit_cnt    <= '0;
      byte_valid <= 1'b0;
    end
    else
    begin
      // flag the byte on the last bit, data is complete in the same cycle
      byte_valid <= frame_active && sck_rise && (bit_cnt == CW'(BW - 1));
      if (!frame_active)
        bit_cnt <= '0;
      else if (sck_rise)
        bit_cnt <= bit_cnt + CW'(1);
    end
  end

  // msb first, shift left on each rising sck
  always_ff @(posedge clk)
  begin
    if (frame_active && sck_rise)
      rx_shift <= {rx_shift[BW-2:0], mosi_q[SYNC_STAGES-2]};
  end

  assign byte_data = rx_shift;

  // a byte only completes inside a frame
  a_byte_in_frame : assert property (
    @(posedge clk) disable iff (!arst_n)
    byte_valid |-> frame_active
  );

endmodule

// ==== source/adc_seq_pkg.sv ====
package adc_seq_pkg;

  //////////////////////////////////////////////////////////////////////
  // conversion result and timing counter
  //////////////////////////////////////////////////////////////////////

  // run-down count and phase timer share this width
  // 32 bits also matches the readback frame length
  parameter int COUNT_W = 32;

  //////////////////////////////////////////////////////////////////////
  // sequencer phases
  //////////////////////////////////////////////////////////////////////

  // idle    : waiting for a start, integrator shorted
  // reset   : integrator held shorted for a fixed time
  // runup   : input integrated for the programmed time
  // rundown : reference integrated until the comparator flips
  typedef enum logic [1:0] {
    PH_IDLE    = 2'd0,
    PH_RESET   = 2'd1,
    PH_RUNUP   = 2'd2,
    PH_RUNDOWN = 2'd3
  } seq_phase_t;

  // switch mapping per phase
  //   idle    m_short=0 m_in=0 m_ref=1
  //   reset   m_short=0 m_in=0 m_ref=1
  //   runup   m_short=1 m_in=0 m_ref=1
  //   rundown m_short=1 m_in=1 m_ref=0

endpackage

// ==== source/adc_spi_pkg.sv ====
package adc_spi_pkg;

  //////////////////////////////////////////////////////////////////////
  // spi framing
  //////////////////////////////////////////////////////////////////////

  // bits per spi byte, shifted in msb first
  parameter int BYTE_W = 8;

  // width of the bit counter inside one byte
  parameter int BIT_CNT_W = $clog2(BYTE_W);

  //////////////////////////////////////////////////////////////////////
  // command opcodes sent by the host
  //////////////////////////////////////////////////////////////////////

  // start a conversion, only taken when the sequencer is idle
  parameter logic [BYTE_W-1:0] OP_START = 8'hCC;

  // set run-up multiplier, one argument byte follows
  // an argument of zero selects the default multiplier
  parameter logic [BYTE_W-1:0] OP_SET_RUNUP = 8'h3A;

  // abort whatever phase is running, back to idle
  parameter logic [BYTE_W-1:0] OP_ABORT = 8'h55;

  // any other byte in opcode position is ignored by the decoder
  // the result is read back on miso during any frame,
  // so no separate read opcode exists

endpackage
